//--- src/axi_bridge_pkg.sv
package axi_bridge_pkg;

    // line geometry
    localparam int LINE_BEATS       = 8;
    localparam int LINE_OFFSET_BITS = 5;

    typedef logic [31:0] addr_t;
    typedef logic [31:0] data_t;
    typedef logic [3:0]  strb_t;
    // beat 0 sits in the low word
    typedef logic [LINE_BEATS*$bits(data_t)-1:0] line_t;
    typedef logic [2:0]  beat_idx_t;

    // axi burst fields
    typedef logic [7:0] axi_len_t;
    typedef logic [2:0] axi_size_t;
    typedef logic [1:0] axi_burst_t;
    typedef logic [3:0] axi_id_t;

    // len field is beats minus one
    localparam axi_len_t   AXI_LEN_LINE   = 8'd7;
    localparam axi_size_t  AXI_SIZE_WORD  = 3'd2;
    localparam axi_burst_t AXI_BURST_INCR = 2'd1;

    // request code from the cache
    typedef enum logic [1:0] {
        REQ_NONE       = 2'd0,
        REQ_LOAD_LINE  = 2'd1,
        REQ_STORE_LINE = 2'd2
    } line_req_e;

    // request controller states
    typedef enum logic [1:0] {
        IDLE   = 2'd0,
        READ   = 2'd1,
        WRITE  = 2'd2,
        FINISH = 2'd3
    } ctrl_state_e;

endpackage

//--- src/line_cmd_if.sv
`timescale 1ns/1ps

interface line_cmd_if import axi_bridge_pkg::*; ();

    // start pulses from the controller
    logic  rd_start;
    logic  wr_start;
    // aligned line address, stable while an engine is busy
    addr_t line_addr;
    line_t wr_line;

    // completion back from the engines
    logic  rd_done;
    logic  wr_done;
    line_t rd_line;

    modport ctrl (
        output rd_start, wr_start, line_addr, wr_line,
        input  rd_done, wr_done, rd_line
    );

    // both engines share this view
    modport engine (
        input  rd_start, wr_start, line_addr, wr_line,
        output rd_done, wr_done, rd_line
    );

endinterface

//--- src/line_request_ctrl.sv
`timescale 1ns/1ps

module line_request_ctrl import axi_bridge_pkg::*; (
    input  logic      clk,
    input  logic      rstn,
    input  line_req_e req,
    input  addr_t     ad,
    input  line_t     wblock,
    output logic      ready,
    output logic      task_finish,
    output line_t     rblock,
    line_cmd_if.ctrl  cmd
);

    ctrl_state_e state;
    logic        accept;

    // a request only counts while idle
    assign accept = (state == IDLE) && (req != REQ_NONE);

    always_ff @(posedge clk) begin
        if (!rstn) begin
            state        <= IDLE;
            cmd.rd_start <= 1'b0;
            cmd.wr_start <= 1'b0;
        end else begin
            cmd.rd_start <= accept && (req == REQ_LOAD_LINE);
            cmd.wr_start <= accept && (req == REQ_STORE_LINE);
            unique case (state)
                IDLE: begin
                    if (req == REQ_LOAD_LINE) begin
                        state <= READ;
                    end else if (req == REQ_STORE_LINE) begin
                        state <= WRITE;
                    end
                end
                READ: begin
                    if (cmd.rd_done) begin
                        state <= FINISH;
                    end
                end
                WRITE: begin
                    if (cmd.wr_done) begin
                        state <= FINISH;
                    end
                end
                FINISH: begin
                    state <= IDLE;
                end
                default: begin
                    state <= IDLE;
                end
            endcase
        end
    end

    // address and store data, latched at acceptance
    always_ff @(posedge clk) begin
        if (accept) begin
            cmd.line_addr <= {ad[$bits(addr_t)-1:LINE_OFFSET_BITS], {LINE_OFFSET_BITS{1'b0}}};
        end
        if (accept && (req == REQ_STORE_LINE)) begin
            cmd.wr_line <= wblock;
        end
    end

    // loaded line held until the next load completes
    always_ff @(posedge clk) begin
        if ((state == READ) && cmd.rd_done) begin
            rblock <= cmd.rd_line;
        end
    end

    assign ready       = (state == IDLE);
    assign task_finish = (state == FINISH);

endmodule

//--- src/line_read_engine.sv
`timescale 1ns/1ps

module line_read_engine import axi_bridge_pkg::*; #(
    parameter axi_id_t READ_ID = 4'd1
) (
    input  logic        clk,
    input  logic        rstn,
    line_cmd_if.engine  cmd,
    // ar channel
    output axi_id_t     arid,
    output addr_t       araddr,
    output axi_len_t    arlen,
    output axi_size_t   arsize,
    output axi_burst_t  arburst,
    output logic        arvalid,
    input  logic        arready,
    // r channel
    input  data_t       rdata,
    input  logic        rlast,
    input  logic        rvalid,
    output logic        rready
);

    beat_idx_t beat;
    line_t     line_q;
    logic      busy;

    // busy from the start until the last beat
    assign busy = arvalid || rready;

    always_ff @(posedge clk) begin
        if (!rstn) begin
            arvalid     <= 1'b0;
            rready      <= 1'b0;
            beat        <= '0;
            cmd.rd_done <= 1'b0;
        end else begin
            cmd.rd_done <= 1'b0;
            if (cmd.rd_start && !busy) begin
                arvalid <= 1'b1;
            end
            if (arvalid && arready) begin
                arvalid <= 1'b0;
                rready  <= 1'b1;
                beat    <= '0;
            end
            if (rvalid && rready) begin
                beat <= beat + 1'b1;
                // rlast closes the burst whatever the count
                if (rlast) begin
                    rready      <= 1'b0;
                    cmd.rd_done <= 1'b1;
                end
            end
        end
    end

    // burst address and gathered words
    always_ff @(posedge clk) begin
        if (cmd.rd_start && !busy) begin
            araddr <= cmd.line_addr;
        end
        if (rvalid && rready) begin
            line_q[beat*$bits(data_t) +: $bits(data_t)] <= rdata;
        end
    end

    assign arid        = READ_ID;
    assign arlen       = AXI_LEN_LINE;
    assign arsize      = AXI_SIZE_WORD;
    assign arburst     = AXI_BURST_INCR;
    assign cmd.rd_line = line_q;

endmodule

//--- src/line_write_engine.sv
`timescale 1ns/1ps

module line_write_engine import axi_bridge_pkg::*; #(
    parameter axi_id_t WRITE_ID = 4'd2
) (
    input  logic        clk,
    input  logic        rstn,
    line_cmd_if.engine  cmd,
    // aw channel
    output axi_id_t     awid,
    output addr_t       awaddr,
    output axi_len_t    awlen,
    output axi_size_t   awsize,
    output axi_burst_t  awburst,
    output logic        awvalid,
    input  logic        awready,
    // w channel
    output data_t       wdata,
    output strb_t       wstrb,
    output logic        wlast,
    output logic        wvalid,
    input  logic        wready,
    // b channel
    input  logic        bvalid,
    output logic        bready
);

    beat_idx_t beat;
    logic      last_beat;
    logic      busy;

    // one of the three phases is active
    assign busy      = awvalid || wvalid || bready;
    assign last_beat = (beat == beat_idx_t'(LINE_BEATS - 1));

    always_ff @(posedge clk) begin
        if (!rstn) begin
            awvalid     <= 1'b0;
            wvalid      <= 1'b0;
            bready      <= 1'b0;
            beat        <= '0;
            cmd.wr_done <= 1'b0;
        end else begin
            cmd.wr_done <= 1'b0;
            // address phase
            if (cmd.wr_start && !busy) begin
                awvalid <= 1'b1;
            end
            if (awvalid && awready) begin
                awvalid <= 1'b0;
                wvalid  <= 1'b1;
                beat    <= '0;
            end
            // data phase, one word per handshake
            if (wvalid && wready) begin
                beat <= beat + 1'b1;
                if (last_beat) begin
                    wvalid <= 1'b0;
                    bready <= 1'b1;
                end
            end
            // response phase
            if (bready && bvalid) begin
                bready      <= 1'b0;
                cmd.wr_done <= 1'b1;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (cmd.wr_start && !busy) begin
            awaddr <= cmd.line_addr;
        end
    end

    // wr_line is held by the controller for the whole burst
    assign wdata = cmd.wr_line[beat*$bits(data_t) +: $bits(data_t)];
    assign wstrb = '1;
    assign wlast = wvalid && last_beat;

    assign awid    = WRITE_ID;
    assign awlen   = AXI_LEN_LINE;
    assign awsize  = AXI_SIZE_WORD;
    assign awburst = AXI_BURST_INCR;

endmodule

//--- src/axi_line_bridge.sv
`timescale 1ns/1ps

module axi_line_bridge import axi_bridge_pkg::*; #(
    parameter axi_id_t READ_ID  = 4'd1,
    parameter axi_id_t WRITE_ID = 4'd2
) (
    input  logic        clk,
    input  logic        rstn,
    // cache side
    input  line_req_e   req,
    input  addr_t       ad,
    input  line_t       wblock,
    output logic        ready,
    output logic        task_finish,
    output line_t       rblock,
    // read address
    output axi_id_t     arid,
    output addr_t       araddr,
    output axi_len_t    arlen,
    output axi_size_t   arsize,
    output axi_burst_t  arburst,
    output logic        arvalid,
    input  logic        arready,
    // read data
    input  data_t       rdata,
    input  logic        rlast,
    input  logic        rvalid,
    output logic        rready,
    // write address
    output axi_id_t     awid,
    output addr_t       awaddr,
    output axi_len_t    awlen,
    output axi_size_t   awsize,
    output axi_burst_t  awburst,
    output logic        awvalid,
    input  logic        awready,
    // write data
    output data_t       wdata,
    output strb_t       wstrb,
    output logic        wlast,
    output logic        wvalid,
    input  logic        wready,
    // write response
    input  logic        bvalid,
    output logic        bready
);

    line_cmd_if cmd_if ();

    line_request_ctrl i_line_request_ctrl (
        .clk         (clk),
        .rstn        (rstn),
        .req         (req),
        .ad          (ad),
        .wblock      (wblock),
        .ready       (ready),
        .task_finish (task_finish),
        .rblock      (rblock),
        .cmd         (cmd_if.ctrl)
    );

    line_read_engine #(
        .READ_ID (READ_ID)
    ) i_line_read_engine (
        .clk     (clk),
        .rstn    (rstn),
        .cmd     (cmd_if.engine),
        .arid    (arid),
        .araddr  (araddr),
        .arlen   (arlen),
        .arsize  (arsize),
        .arburst (arburst),
        .arvalid (arvalid),
        .arready (arready),
        .rdata   (rdata),
        .rlast   (rlast),
        .rvalid  (rvalid),
        .rready  (rready)
    );

    line_write_engine #(
        .WRITE_ID (WRITE_ID)
    ) i_line_write_engine (
        .clk     (clk),
        .rstn    (rstn),
        .cmd     (cmd_if.engine),
        .awid    (awid),
        .awaddr  (awaddr),
        .awlen   (awlen),
        .awsize  (awsize),
        .awburst (awburst),
        .awvalid (awvalid),
        .awready (awready),
        .wdata   (wdata),
        .wstrb   (wstrb),
        .wlast   (wlast),
        .wvalid  (wvalid),
        .wready  (wready),
        .bvalid  (bvalid),
        .bready  (bready)
    );

endmodule

//--- verification/axi_mem_model.sv
`timescale 1ns/1ps

module axi_mem_model import axi_bridge_pkg::*; (
    input  logic       clk,
    input  logic       rstn,
    input  addr_t      araddr,
    input  logic       arvalid,
    output logic       arready,
    output data_t      rdata,
    output logic       rlast,
    output logic       rvalid,
    input  logic       rready,
    input  addr_t      awaddr,
    input  logic       awvalid,
    output logic       awready,
    input  data_t      wdata,
    input  logic       wvalid,
    output logic       wready,
    output logic       bvalid,
    input  logic       bready
);

    data_t       mem [256];
    logic [31:0] rng;
    int          ar_count;
    int          aw_count;
    logic        rd_active;
    logic [7:0]  rd_idx;
    logic [2:0]  rd_beat;
    logic        wr_active;
    logic [7:0]  wr_idx;
    logic [2:0]  wr_beat;
    logic        b_pend;

    function automatic logic [31:0] xorshift32(input logic [31:0] x);
        logic [31:0] y;
        y = x ^ (x << 13);
        y = y ^ (y >> 17);
        y = y ^ (y << 5);
        return y;
    endfunction

    // preload mixes in the word index so every address differs
    initial begin
        logic [31:0] v;
        v = 32'hfb88_3fd7;
        for (int i = 0; i < 256; i++) begin
            v = xorshift32(v);
            mem[i] = v ^ (32'(i) * 32'h9e37_79b9);
        end
        rng = 32'hfb88_3fd7;
    end

    always @(posedge clk) begin
        if (!rstn) begin
            arready <= 1'b0;
            rvalid <= 1'b0;
            rlast <= 1'b0;
            rdata <= '0;
            awready <= 1'b0;
            wready <= 1'b0;
            bvalid <= 1'b0;
            rd_active <= 1'b0;
            wr_active <= 1'b0;
            b_pend <= 1'b0;
            rd_beat <= '0;
            wr_beat <= '0;
            ar_count <= 0;
            aw_count <= 0;
        end else begin
            rng <= xorshift32(rng);
            // read address, one burst at a time
            if (arvalid && arready) begin
                rd_active <= 1'b1;
                rd_idx <= araddr[9:2];
                rd_beat <= '0;
                arready <= 1'b0;
                ar_count <= ar_count + 1;
            end else if (!rd_active) begin
                arready <= rng[0];
            end
            // read data with random gaps
            if (rd_active) begin
                if (rvalid && rready) begin
                    if (rd_beat == 3'd7) begin
                        rd_active <= 1'b0;
                        rvalid <= 1'b0;
                        rlast <= 1'b0;
                    end else begin
                        rd_beat <= rd_beat + 3'd1;
                        rvalid <= rng[1];
                        rdata <= mem[rd_idx + 8'(rd_beat) + 8'd1];
                        rlast <= (rd_beat == 3'd6);
                    end
                end else if (!rvalid) begin
                    rvalid <= rng[1];
                    rdata <= mem[rd_idx + 8'(rd_beat)];
                    rlast <= (rd_beat == 3'd7);
                end
            end
            // write address
            if (awvalid && awready) begin
                wr_active <= 1'b1;
                wr_idx <= awaddr[9:2];
                wr_beat <= '0;
                awready <= 1'b0;
                aw_count <= aw_count + 1;
            end else if (!wr_active && !b_pend) begin
                awready <= rng[2];
            end
            // write data, stored on each handshake
            if (wr_active) begin
                wready <= rng[3];
                if (wvalid && wready) begin
                    mem[wr_idx + 8'(wr_beat)] <= wdata;
                    wr_beat <= wr_beat + 3'd1;
                    if (wr_beat == 3'd7) begin
                        wr_active <= 1'b0;
                        wready <= 1'b0;
                        b_pend <= 1'b1;
                    end
                end
            end
            // write response
            if (bvalid && bready) begin
                bvalid <= 1'b0;
                b_pend <= 1'b0;
            end else if (b_pend && !bvalid) begin
                bvalid <= rng[4];
            end
        end
    end

endmodule

//--- verification/tb_axi_line_bridge.sv
`timescale 1ns/1ps

module tb_axi_line_bridge import axi_bridge_pkg::*; ();

    localparam axi_id_t READ_ID  = 4'd5;
    localparam axi_id_t WRITE_ID = 4'd9;
    localparam int      TIMEOUT  = 400;

    logic       clk;
    logic       rstn;
    line_req_e  req;
    addr_t      ad;
    line_t      wblock;
    logic       ready;
    logic       task_finish;
    line_t      rblock;
    axi_id_t    arid;
    axi_id_t    awid;
    addr_t      araddr;
    addr_t      awaddr;
    axi_len_t   arlen;
    axi_len_t   awlen;
    axi_size_t  arsize;
    axi_size_t  awsize;
    axi_burst_t arburst;
    axi_burst_t awburst;
    logic       arvalid, arready, rlast, rvalid, rready;
    logic       awvalid, awready, wlast, wvalid, wready, bvalid, bready;
    data_t      rdata;
    data_t      wdata;
    strb_t      wstrb;

    int          errors;
    int          timeouts;
    int          loads;
    int          stores;
    int          finishes;
    int          w_beats;
    logic [31:0] rng;
    addr_t       exp_addr;
    string       test_name;

    axi_line_bridge #(
        .READ_ID  (READ_ID),
        .WRITE_ID (WRITE_ID)
    ) i_axi_line_bridge (
        .clk (clk), .rstn (rstn), .req (req), .ad (ad), .wblock (wblock),
        .ready (ready), .task_finish (task_finish), .rblock (rblock),
        .arid (arid), .araddr (araddr), .arlen (arlen), .arsize (arsize),
        .arburst (arburst), .arvalid (arvalid), .arready (arready),
        .rdata (rdata), .rlast (rlast), .rvalid (rvalid), .rready (rready),
        .awid (awid), .awaddr (awaddr), .awlen (awlen), .awsize (awsize),
        .awburst (awburst), .awvalid (awvalid), .awready (awready),
        .wdata (wdata), .wstrb (wstrb), .wlast (wlast), .wvalid (wvalid),
        .wready (wready), .bvalid (bvalid), .bready (bready)
    );

    axi_mem_model i_mem (
        .clk (clk), .rstn (rstn),
        .araddr (araddr), .arvalid (arvalid), .arready (arready),
        .rdata (rdata), .rlast (rlast), .rvalid (rvalid), .rready (rready),
        .awaddr (awaddr), .awvalid (awvalid), .awready (awready),
        .wdata (wdata), .wvalid (wvalid), .wready (wready),
        .bvalid (bvalid), .bready (bready)
    );

    initial begin
        clk = 1'b0;
        forever #4 clk = ~clk;
    end

    function automatic logic [31:0] xorshift32(input logic [31:0] x);
        logic [31:0] y;
        y = x ^ (x << 13);
        y = y ^ (y >> 17);
        y = y ^ (y << 5);
        return y;
    endfunction

    // eight words from the model, beat 0 in the low word
    function automatic line_t mem_line(input addr_t a);
        line_t l;
        for (int k = 0; k < LINE_BEATS; k++) begin
            l[k*32 +: 32] = i_mem.mem[a[9:2] + 8'(k)];
        end
        return l;
    endfunction

    task automatic expect_equal(input string name, input logic [31:0] exp,
                                input logic [31:0] act);
        if (act !== exp) begin
            errors++;
            $display("ERROR %s expected %h actual %h", name, exp, act);
        end
    endtask

    task automatic compare_line(input string name, input line_t exp, input line_t act);
        if (act !== exp) begin
            errors++;
            $display("ERROR %s expected %h actual %h", name, exp, act);
        end
    endtask

    task automatic verify_idle(input string name);
        expect_equal({name, " arvalid"}, 0, 32'(arvalid));
        expect_equal({name, " awvalid"}, 0, 32'(awvalid));
        expect_equal({name, " wvalid"}, 0, 32'(wvalid));
        expect_equal({name, " rready"}, 0, 32'(rready));
        expect_equal({name, " bready"}, 0, 32'(bready));
        expect_equal({name, " task_finish"}, 0, 32'(task_finish));
    endtask

    task automatic wait_ready();
        int n;
        n = 0;
        while (ready !== 1'b1 && n < TIMEOUT) begin
            @(posedge clk);
            #1;
            n++;
        end
        if (ready !== 1'b1) begin
            timeouts++;
            $display("%s: timed out waiting for ready", test_name);
        end
    endtask

    // one line operation, optionally with a stray request while busy
    task automatic run_line_op(input line_req_e kind, input addr_t a, input line_t l,
                               input bit stray);
        int n;
        wait_ready();
        req = kind;
        ad = a;
        wblock = l;
        exp_addr = {a[31:5], 5'b0};
        @(posedge clk);
        #1;
        req = REQ_NONE;
        if (kind == REQ_LOAD_LINE) loads++;
        else stores++;
        n = 0;
        while (task_finish !== 1'b1 && n < TIMEOUT) begin
            if (stray && n == 2) begin
                req = (kind == REQ_LOAD_LINE) ? REQ_STORE_LINE : REQ_LOAD_LINE;
                ad = a + 32'h40;
            end else begin
                req = REQ_NONE;
            end
            @(posedge clk);
            #1;
            n++;
        end
        req = REQ_NONE;
        if (task_finish !== 1'b1) begin
            timeouts++;
            $display("%s: timed out waiting for task_finish", test_name);
        end else if (kind == REQ_LOAD_LINE) begin
            compare_line({test_name, " rblock"}, mem_line(exp_addr), rblock);
        end else begin
            compare_line({test_name, " memory"}, l, mem_line(exp_addr));
        end
        @(posedge clk);
        #1;
        expect_equal({test_name, " ready after finish"}, 1, 32'(ready));
    endtask

    function automatic line_t random_line();
        line_t l;
        for (int k = 0; k < LINE_BEATS; k++) begin
            rng = xorshift32(rng);
            l[k*32 +: 32] = rng;
        end
        return l;
    endfunction

    // W handshake count inside the current burst, and finish pulses
    always @(posedge clk) begin
        if (!rstn) begin
            w_beats <= 0;
            finishes <= 0;
        end else begin
            if (task_finish) finishes <= finishes + 1;
            if (awvalid && awready) w_beats <= 0;
            if (wvalid && wready) begin
                expect_equal({test_name, " wlast"}, 32'(w_beats == 7), 32'(wlast));
                w_beats <= w_beats + 1;
            end
        end
    end

    a_ar_addr: assert property (@(posedge clk) disable iff (!rstn)
        (arvalid && arready) |-> (araddr == exp_addr && araddr[4:0] == 5'd0))
        else begin
            errors++;
            $display("ERROR %s araddr expected %h actual %h", test_name, exp_addr, araddr);
        end
    // len 7, size 2, INCR burst
    a_ar_fields: assert property (@(posedge clk) disable iff (!rstn)
        (arvalid && arready) |-> ({arid, arlen, arsize, arburst} ==
        {READ_ID, 8'd7, 3'd2, 2'd1}))
        else begin
            errors++;
            $display("ERROR %s ar fields expected %h actual %h", test_name,
                {READ_ID, 8'd7, 3'd2, 2'd1},
                {arid, arlen, arsize, arburst});
        end
    a_aw_addr: assert property (@(posedge clk) disable iff (!rstn)
        (awvalid && awready) |-> (awaddr == exp_addr && awaddr[4:0] == 5'd0))
        else begin
            errors++;
            $display("ERROR %s awaddr expected %h actual %h", test_name, exp_addr, awaddr);
        end
    a_aw_fields: assert property (@(posedge clk) disable iff (!rstn)
        (awvalid && awready) |-> ({awid, awlen, awsize, awburst} ==
        {WRITE_ID, 8'd7, 3'd2, 2'd1}))
        else begin
            errors++;
            $display("ERROR %s aw fields expected %h actual %h", test_name,
                {WRITE_ID, 8'd7, 3'd2, 2'd1},
                {awid, awlen, awsize, awburst});
        end
    a_wstrb: assert property (@(posedge clk) disable iff (!rstn) wvalid |-> wstrb == 4'hf)
        else begin
            errors++;
            $display("ERROR %s wstrb expected f actual %h", test_name, wstrb);
        end
    a_w_hold: assert property (@(posedge clk) disable iff (!rstn)
        (wvalid && !wready) |=> (wvalid && $stable(wdata) && $stable(wlast)))
        else begin
            errors++;
            $display("%s: wvalid or wdata changed while wready was low", test_name);
        end
    a_ar_hold: assert property (@(posedge clk) disable iff (!rstn)
        (arvalid && !arready) |=> (arvalid && $stable(araddr)))
        else begin
            errors++;
            $display("%s: AR request changed before its handshake", test_name);
        end
    a_aw_hold: assert property (@(posedge clk) disable iff (!rstn)
        (awvalid && !awready) |=> (awvalid && $stable(awaddr)))
        else begin
            errors++;
            $display("%s: AW request changed before its handshake", test_name);
        end

    initial begin
        line_t l;
        addr_t a;
        errors = 0;
        timeouts = 0;
        loads = 0;
        stores = 0;
        rng = 32'hfb88_3fd7;
        rstn = 1'b0;
        req = REQ_NONE;
        ad = '0;
        wblock = '0;
        exp_addr = '0;
        test_name = "reset";
        for (int c = 0; c < 8; c++) begin
            @(posedge clk);
            #1;
            verify_idle("reset");
            expect_equal("reset ready", 1, 32'(ready));
        end
        rstn = 1'b1;
        @(posedge clk);
        #1;
        verify_idle("after reset");
        expect_equal("after reset ready", 1, 32'(ready));

        test_name = "line_load";
        for (int i = 0; i < 4; i++) begin
            rng = xorshift32(rng);
            run_line_op(REQ_LOAD_LINE, {22'd0, rng[9:0]}, '0, 1'b0);
        end

        test_name = "store_readback";
        for (int i = 0; i < 4; i++) begin
            rng = xorshift32(rng);
            a = {22'd0, rng[9:0]};
            l = random_line();
            run_line_op(REQ_STORE_LINE, a, l, 1'b0);
            run_line_op(REQ_LOAD_LINE, a, '0, 1'b0);
            compare_line("store_readback rblock", l, rblock);
        end

        test_name = "ignored_req";
        rng = xorshift32(rng);
        run_line_op(REQ_LOAD_LINE, {22'd0, rng[9:0]}, '0, 1'b1);
        rng = xorshift32(rng);
        a = {22'd0, rng[9:0]};
        l = random_line();
        run_line_op(REQ_STORE_LINE, a, l, 1'b1);
        repeat (20) @(posedge clk);
        #1;
        expect_equal("ignored_req ar bursts", 32'(loads), 32'(i_mem.ar_count));
        expect_equal("ignored_req aw bursts", 32'(stores), 32'(i_mem.aw_count));
        expect_equal("ignored_req finishes", 32'(loads + stores), 32'(finishes));

        $display("errors: %0d, timeouts: %0d", errors, timeouts);
        if (errors == 0 && timeouts == 0) begin
            $display("all tests passed");
        end else begin
            $display("tests failed");
        end
        $finish;
    end

endmodule

//--- tb.f
src/axi_bridge_pkg.sv
src/line_cmd_if.sv
src/line_request_ctrl.sv
src/line_read_engine.sv
src/line_write_engine.sv
src/axi_line_bridge.sv
verification/axi_mem_model.sv
verification/tb_axi_line_bridge.sv

//--- run.sh
#!/bin/sh
set -e

cd "$(dirname "$0")"

verilator --binary --timing --assert -j 0 \
    --top-module tb_axi_line_bridge \
    -f tb.f -o sim_tb

./obj_dir/sim_tb > sim.log 2>&1 || true
cat sim.log

grep -q "all tests passed" sim.log
